/* Bender.yml */
package:
  name: mesh_router

sources:
  - files:
      - design/router_pkg.sv
      - design/input_buffer.sv
      - design/route_selector.sv
      - design/output_port.sv
      - design/mesh_router.sv
  - target: test
    files:
      - tb/mesh_router_sva.sv
      - tb/mesh_router_tb.sv

export_include_dirs: []

dependencies: {}

/* design/input_buffer.sv */
`timescale 1ns/100ps

module input_buffer #(
  parameter int FIFO_DEPTH = 4
) (
  input logic clk,
  input logic rst_n,
  input logic in_valid,
  output logic in_ready,
  input logic in_head,
  input logic in_tail,
  input router_pkg::flit_word in_data,
  output logic buf_valid,
  input logic buf_ready,
  output logic buf_head,
  output logic buf_tail,
  output router_pkg::flit_word buf_data
);

  localparam int ptr_width = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int count_width = $clog2(FIFO_DEPTH + 1);
  localparam int entry_width = router_pkg::data_width + 2;
  localparam logic [ptr_width-1:0] last_ptr = ptr_width'(FIFO_DEPTH - 1);
  localparam logic [count_width-1:0] full_count = count_width'(FIFO_DEPTH);

  // Head and tail markers sit above the data word
  logic [entry_width-1:0] mem [FIFO_DEPTH];
  logic [entry_width-1:0] rd_entry;
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [count_width-1:0] count;
  logic push;
  logic pop;

  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    return (ptr == last_ptr) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready = (count != full_count);
  assign buf_valid = (count != '0);
  assign push = in_valid && in_ready;
  assign pop = buf_valid && buf_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {in_head, in_tail, in_data.payload};
    end
  end

  assign rd_entry = mem[rd_ptr];
  assign buf_head = rd_entry[entry_width-1];
  assign buf_tail = rd_entry[entry_width-2];
  assign buf_data.payload = rd_entry[router_pkg::data_width-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* design/mesh_router.sv */
`timescale 1ns/100ps

module mesh_router #(
  parameter int X = 0,
  parameter int Y = 0,
  parameter int SIZE_X = 4,
  parameter int SIZE_Y = 4,
  parameter bit [router_pkg::num_ports-1:0] AVAILABLE_PORTS = '1,
  parameter int FIFO_DEPTH = 4
) (
  input logic clk,
  input logic rst_n,
  input logic [router_pkg::num_ports-1:0] in_valid,
  output logic [router_pkg::num_ports-1:0] in_ready,
  input logic [router_pkg::num_ports-1:0] in_head,
  input logic [router_pkg::num_ports-1:0] in_tail,
  input router_pkg::flit_word in_data [router_pkg::num_ports],
  output logic [router_pkg::num_ports-1:0] out_valid,
  input logic [router_pkg::num_ports-1:0] out_ready,
  output logic [router_pkg::num_ports-1:0] out_head,
  output logic [router_pkg::num_ports-1:0] out_tail,
  output router_pkg::flit_word out_data [router_pkg::num_ports]
);

  localparam int ports = router_pkg::num_ports;

  logic [ports-1:0] gated_valid;
  logic [ports-1:0] fifo_ready;
  logic [ports-1:0] buf_valid;
  logic [ports-1:0] buf_ready;
  logic [ports-1:0] buf_head;
  logic [ports-1:0] buf_tail;
  router_pkg::flit_word buf_data [ports];
  logic [ports-1:0] sel_valid;
  logic [ports-1:0] sel_ready;
  logic [ports-1:0] sel_head;
  logic [ports-1:0] sel_tail;
  router_pkg::flit_word sel_data [ports];
  logic [ports-1:0] route [ports];
  logic [ports-1:0] port_request [ports];
  logic [ports-1:0] port_grant [ports];
  logic [ports-1:0] port_accept;

  // Disabled inputs never accept
  assign gated_valid = in_valid & AVAILABLE_PORTS;
  assign in_ready = fifo_ready & AVAILABLE_PORTS;

  for (genvar i = 0; i < ports; i++) begin : g_input
    input_buffer #(
      .FIFO_DEPTH(FIFO_DEPTH)
    ) input_buffer_i (
      .clk(clk),
      .rst_n(rst_n),
      .in_valid(gated_valid[i]),
      .in_ready(fifo_ready[i]),
      .in_head(in_head[i]),
      .in_tail(in_tail[i]),
      .in_data(in_data[i]),
      .buf_valid(buf_valid[i]),
      .buf_ready(buf_ready[i]),
      .buf_head(buf_head[i]),
      .buf_tail(buf_tail[i]),
      .buf_data(buf_data[i])
    );

    route_selector #(
      .X(X),
      .Y(Y),
      .SIZE_X(SIZE_X),
      .SIZE_Y(SIZE_Y),
      .AVAILABLE_PORTS(AVAILABLE_PORTS)
    ) route_selector_i (
      .clk(clk),
      .rst_n(rst_n),
      .buf_valid(buf_valid[i]),
      .buf_ready(buf_ready[i]),
      .buf_head(buf_head[i]),
      .buf_tail(buf_tail[i]),
      .buf_data(buf_data[i]),
      .sel_valid(sel_valid[i]),
      .sel_ready(sel_ready[i]),
      .route(route[i]),
      .sel_head(sel_head[i]),
      .sel_tail(sel_tail[i]),
      .sel_data(sel_data[i])
    );
  end

  // Request of input i to output j
  always_comb begin
    for (int j = 0; j < ports; j++) begin
      for (int i = 0; i < ports; i++) begin
        port_request[j][i] = sel_valid[i] & route[i][j];
      end
    end
  end

  // Input is ready when a granting output can take the flit
  always_comb begin
    sel_ready = '0;
    for (int i = 0; i < ports; i++) begin
      for (int j = 0; j < ports; j++) begin
        sel_ready[i] = sel_ready[i] | (port_grant[j][i] & port_accept[j]);
      end
    end
  end

  for (genvar j = 0; j < ports; j++) begin : g_output
    if (AVAILABLE_PORTS[j]) begin : g_port
      output_port output_port_i (
        .clk(clk),
        .rst_n(rst_n),
        .request(port_request[j]),
        .req_head(sel_head),
        .req_tail(sel_tail),
        .req_data(sel_data),
        .grant(port_grant[j]),
        .accept(port_accept[j]),
        .out_valid(out_valid[j]),
        .out_ready(out_ready[j]),
        .out_head(out_head[j]),
        .out_tail(out_tail[j]),
        .out_data(out_data[j])
      );
    end else begin : g_off
      assign port_grant[j] = '0;
      assign port_accept[j] = 1'b0;
      assign out_valid[j] = 1'b0;
      assign out_head[j] = 1'b0;
      assign out_tail[j] = 1'b0;
      assign out_data[j] = '0;
    end
  end

endmodule

/* design/output_port.sv */
`timescale 1ns/100ps

module output_port (
  input logic clk,
  input logic rst_n,
  input logic [router_pkg::num_ports-1:0] request,
  input logic [router_pkg::num_ports-1:0] req_head,
  input logic [router_pkg::num_ports-1:0] req_tail,
  input router_pkg::flit_word req_data [router_pkg::num_ports],
  output logic [router_pkg::num_ports-1:0] grant,
  output logic accept,
  output logic out_valid,
  input logic out_ready,
  output logic out_head,
  output logic out_tail,
  output router_pkg::flit_word out_data
);

  localparam int ports = router_pkg::num_ports;
  localparam int idx_width = router_pkg::port_idx_width;

  logic locked;
  logic [ports-1:0] lock_grant;
  logic [ports-1:0] idle_grant;
  logic [idx_width-1:0] last_winner;
  logic [idx_width-1:0] grant_idx;
  logic mux_valid;
  logic mux_head;
  logic mux_tail;
  router_pkg::flit_word mux_data;
  logic transfer;

  // Round robin over inputs presenting a head flit
  always_comb begin : rr_pick
    int idx;
    logic found;
    idle_grant = '0;
    found = 1'b0;
    for (int k = 1; k <= ports; k++) begin
      idx = (int'(last_winner) + k) % ports;
      if (!found && request[idx] && req_head[idx]) begin
        idle_grant[idx] = 1'b1;
        found = 1'b1;
      end
    end
  end

  assign grant = locked ? lock_grant : idle_grant;

  // Flit multiplexer on a one-hot or empty grant
  always_comb begin
    grant_idx = '0;
    mux_head = 1'b0;
    mux_tail = 1'b0;
    mux_data = '0;
    for (int i = 0; i < ports; i++) begin
      if (grant[i]) begin
        grant_idx = idx_width'(i);
        mux_head = req_head[i];
        mux_tail = req_tail[i];
        mux_data = req_data[i];
      end
    end
  end

  assign mux_valid = |(grant & request);
  assign accept = !out_valid || out_ready;
  assign transfer = mux_valid && accept;

  // Packet lock from head to tail
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      locked <= 1'b0;
      lock_grant <= '0;
      last_winner <= idx_width'(ports - 1);
    end else if (transfer) begin
      if (!locked) begin
        last_winner <= grant_idx;
      end
      if (mux_tail) begin
        locked <= 1'b0;
        lock_grant <= '0;
      end else if (!locked) begin
        locked <= 1'b1;
        lock_grant <= grant;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= mux_valid;
    end
  end

  // Output register holds its flit while stalled
  always_ff @(posedge clk) begin
    if (accept) begin
      out_head <= mux_head;
      out_tail <= mux_tail;
      out_data.payload <= mux_data.payload;
    end
  end

endmodule

/* design/route_selector.sv */
`timescale 1ns/100ps

module route_selector #(
  parameter int X = 0,
  parameter int Y = 0,
  parameter int SIZE_X = 4,
  parameter int SIZE_Y = 4,
  parameter bit [router_pkg::num_ports-1:0] AVAILABLE_PORTS = '1
) (
  input logic clk,
  input logic rst_n,
  input logic buf_valid,
  output logic buf_ready,
  input logic buf_head,
  input logic buf_tail,
  input router_pkg::flit_word buf_data,
  output logic sel_valid,
  input logic sel_ready,
  output logic [router_pkg::num_ports-1:0] route,
  output logic sel_head,
  output logic sel_tail,
  output router_pkg::flit_word sel_data
);

  localparam int ports = router_pkg::num_ports;

  logic [router_pkg::coord_width-1:0] dest_x;
  logic [router_pkg::coord_width-1:0] dest_y;
  logic [ports-1:0] route_choice;
  logic [ports-1:0] route_next;
  logic [ports-1:0] route_hold;
  logic start_of_packet;
  logic end_of_packet;
  logic dest_outside;

  assign dest_x = buf_data.header.dest_x;
  assign dest_y = buf_data.header.dest_y;

  // XY order with X resolved first
  always_comb begin
    route_choice = '0;
    if (int'(dest_x) > X) begin
      route_choice[router_pkg::port_xp] = 1'b1;
    end else if (int'(dest_x) < X) begin
      route_choice[router_pkg::port_xm] = 1'b1;
    end else if (int'(dest_y) > Y) begin
      route_choice[router_pkg::port_yp] = 1'b1;
    end else if (int'(dest_y) < Y) begin
      route_choice[router_pkg::port_ym] = 1'b1;
    end else begin
      route_choice[router_pkg::port_local] = 1'b1;
    end
  end

  // Masked off direction falls back to local
  always_comb begin
    route_next = route_choice;
    if ((route_choice & AVAILABLE_PORTS) == '0) begin
      route_next = '0;
      route_next[router_pkg::port_local] = 1'b1;
    end
  end

  assign start_of_packet = buf_valid && buf_head;
  assign end_of_packet = buf_valid && buf_ready && buf_tail;

  assign route = start_of_packet ? route_next : route_hold;

  // Held for body flits and never stored for single flit packets
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      route_hold <= '0;
    end else if (end_of_packet) begin
      route_hold <= '0;
    end else if (start_of_packet && !buf_tail) begin
      route_hold <= route_next;
    end
  end

  assign buf_ready = sel_ready && (route != '0);
  assign sel_valid = buf_valid;
  assign sel_head = buf_head;
  assign sel_tail = buf_tail;

  // Range check uses the raw coordinates
  assign dest_outside = (int'(dest_x) >= SIZE_X) || (int'(dest_y) >= SIZE_Y);

  always_comb begin
    sel_data = buf_data;
    if (buf_head && dest_outside) begin
      sel_data.header.invalid_destination = 1'b1;
    end
  end

endmodule

/* design/router_pkg.sv */
package router_pkg;

  // Router ports
  localparam int num_ports = 5;
  localparam int port_idx_width = $clog2(num_ports);

  // Port indices double as bit positions in route words and the port mask
  localparam int port_xp = 0;
  localparam int port_xm = 1;
  localparam int port_yp = 2;
  localparam int port_ym = 3;
  localparam int port_local = 4;

  // Mesh coordinates
  localparam int coord_width = 4;

  // Flit word
  localparam int data_width = 32;
  localparam int reserved_width = data_width - 1 - 4 * coord_width;

  // Routing view of the first word of a packet
  typedef struct packed {
    logic invalid_destination;
    logic [coord_width-1:0] dest_x;
    logic [coord_width-1:0] dest_y;
    logic [coord_width-1:0] src_x;
    logic [coord_width-1:0] src_y;
    logic [reserved_width-1:0] reserved;
  } flit_header;

  // Head flits are read through the header view and body flits as raw payload
  typedef union packed {
    flit_header header;
    logic [data_width-1:0] payload;
  } flit_word;

endpackage

/* project.f */
design/router_pkg.sv
design/input_buffer.sv
design/route_selector.sv
design/output_port.sv
design/mesh_router.sv
tb/mesh_router_sva.sv
tb/mesh_router_tb.sv

/* tb/mesh_router_sva.sv */
`timescale 1ns/100ps

module mesh_router_sva #(
  parameter bit [router_pkg::num_ports-1:0] AVAILABLE_PORTS = '1
) (
  input logic clk,
  input logic rst_n,
  input logic [router_pkg::num_ports-1:0] in_valid,
  input logic [router_pkg::num_ports-1:0] in_ready,
  input logic [router_pkg::num_ports-1:0] out_valid,
  input logic [router_pkg::num_ports-1:0] out_ready,
  input logic [router_pkg::num_ports-1:0] out_head,
  input logic [router_pkg::num_ports-1:0] out_tail,
  input router_pkg::flit_word out_data [router_pkg::num_ports]
);

  int failures = 0;

  for (genvar j = 0; j < router_pkg::num_ports; j++) begin : g_port
    // Stalled flit stays put
    hold_flit: assert property (
      @(posedge clk) disable iff (!rst_n)
      out_valid[j] && !out_ready[j] |=> out_valid[j] && $stable(out_head[j])
        && $stable(out_tail[j]) && $stable(out_data[j].payload)
    ) else begin
      $error("Output %0d changed a stalled flit", j);
      failures++;
    end

    if (!AVAILABLE_PORTS[j]) begin : g_off
      off_quiet: assert property (
        @(posedge clk) disable iff (!rst_n) !out_valid[j]
      ) else begin
        $error("Disabled output %0d raised out_valid", j);
        failures++;
      end

      off_closed: assert property (
        @(posedge clk) disable iff (!rst_n) !(in_valid[j] && in_ready[j])
      ) else begin
        $error("Disabled input %0d accepted a flit", j);
        failures++;
      end
    end
  end

endmodule

/* tb/mesh_router_tb.sv */
`timescale 1ns/100ps

module mesh_router_tb;

  localparam int ports = router_pkg::num_ports;
  localparam int mesh_size = 4;
  localparam bit [ports-1:0] port_mask = 5'b10111;
  localparam int port_off = router_pkg::port_ym;
  localparam int reset_cycles = 8;
  localparam int cycles_per_vector = 40;

  logic clk;
  logic rst_n;
  logic [ports-1:0] in_valid;
  logic [ports-1:0] in_ready;
  logic [ports-1:0] in_head;
  logic [ports-1:0] in_tail;
  router_pkg::flit_word in_data [ports];
  logic [ports-1:0] out_valid;
  logic [ports-1:0] out_ready;
  logic [ports-1:0] out_head;
  logic [ports-1:0] out_tail;
  router_pkg::flit_word out_data [ports];

  int vec_port[$];
  bit vec_head[$];
  bit vec_tail[$];
  logic [31:0] vec_data[$];
  int vec_out[$];
  int num_vec;

  // Vector indices still expected per slot out * ports + src
  int exp_q [ports*ports][$];
  int open_src [ports];
  int outstanding;
  int checked;
  int value_errors;
  int other_errors;

  logic [31:0] lfsr = 32'd82052;
  logic [ports-1:0] ready_next;
  logic [ports-1:0] stalled;
  logic [33:0] stalled_flit [ports];

  mesh_router #(
    .X(1),
    .Y(1),
    .SIZE_X(mesh_size),
    .SIZE_Y(mesh_size),
    .AVAILABLE_PORTS(port_mask),
    .FIFO_DEPTH(4)
  ) dut_i (
    .clk(clk),
    .rst_n(rst_n),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_head(in_head),
    .in_tail(in_tail),
    .in_data(in_data),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_head(out_head),
    .out_tail(out_tail),
    .out_data(out_data)
  );

  bind mesh_router mesh_router_sva #(
    .AVAILABLE_PORTS(AVAILABLE_PORTS)
  ) sva_i (
    .clk(clk),
    .rst_n(rst_n),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_head(out_head),
    .out_tail(out_tail),
    .out_data(out_data)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // Heads outside the 4x4 mesh carry the invalid_destination bit
  function automatic logic [31:0] expected_word(input int k);
    router_pkg::flit_word w;
    w.payload = vec_data[k];
    if (vec_head[k] && (int'(w.header.dest_x) >= mesh_size
        || int'(w.header.dest_y) >= mesh_size)) begin
      w.header.invalid_destination = 1'b1;
    end
    return w.payload;
  endfunction

  task automatic load_vectors();
    int fd;
    int fields;
    int port;
    int head;
    int tail;
    int out;
    logic [31:0] data;
    string line;
    fd = $fopen("tb/router_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open tb/router_vectors.txt");
      other_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      fields = $sscanf(line, "%h %h %h %h %h", port, head, tail, data, out);
      if (fields == 5) begin
        if (port >= ports || out >= ports || !port_mask[port]) begin
          $display("Vector line names an unusable port: %s", line);
          other_errors++;
        end else begin
          vec_port.push_back(port);
          vec_head.push_back(head[0]);
          vec_tail.push_back(tail[0]);
          vec_data.push_back(data);
          vec_out.push_back(out);
        end
      end
    end
    $fclose(fd);
  endtask

  // One flit per handshake in file order
  task automatic drive_port(input int p);
    for (int k = 0; k < num_vec; k++) begin
      if (vec_port[k] == p) begin
        in_valid[p] <= 1'b1;
        in_head[p] <= vec_head[k];
        in_tail[p] <= vec_tail[k];
        in_data[p].payload <= vec_data[k];
        @(posedge clk);
        while (!in_ready[p]) begin
          @(posedge clk);
        end
      end
    end
    in_valid[p] <= 1'b0;
  endtask

  task automatic check_flit(input int j);
    int k;
    logic [31:0] got;
    got = out_data[j].payload;
    if (out_head[j]) begin
      assert (open_src[j] < 0) else begin
        other_errors++;
        $display("Head flit on output %0d at %0t cut into an open packet", j, $time);
      end
      open_src[j] = -1;
      for (int i = 0; i < ports; i++) begin
        if (exp_q[j*ports+i].size() > 0) begin
          k = exp_q[j*ports+i][0];
          if (vec_head[k] && expected_word(k) == got) begin
            open_src[j] = i;
          end
        end
      end
    end
    assert (open_src[j] >= 0) else begin
      other_errors++;
      $display("Output %0d sent flit %h at %0t that no packet expects", j, got, $time);
    end
    if (open_src[j] < 0) begin
      return;
    end
    k = exp_q[j*ports+open_src[j]].pop_front();
    outstanding--;
    checked++;
    assert (got == expected_word(k)) else begin
      value_errors++;
      $display("FAIL %0t out_data[%0d] expected %h got %h", $time, j, expected_word(k), got);
    end
    assert (out_head[j] == vec_head[k] && out_tail[j] == vec_tail[k]) else begin
      value_errors++;
      $display("FAIL %0t out_head/out_tail[%0d] expected %b%b got %b%b", $time, j,
               vec_head[k], vec_tail[k], out_head[j], out_tail[j]);
    end
    if (out_tail[j]) begin
      open_src[j] = -1;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Output back-pressure with ready three cycles in four on average
  always @(posedge clk) begin
    for (int j = 0; j < ports; j++) begin
      lfsr = lfsr_step(lfsr);
      ready_next[j] = lfsr[0];
      lfsr = lfsr_step(lfsr);
      ready_next[j] = ready_next[j] | lfsr[0];
    end
    out_ready <= ready_next;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      stalled = '0;
    end else begin
      for (int j = 0; j < ports; j++) begin
        if (stalled[j]) begin
          assert (out_valid[j]) else begin
            other_errors++;
            $display("Output %0d dropped out_valid while stalled at %0t", j, $time);
          end
          assert ({out_head[j], out_tail[j], out_data[j].payload} == stalled_flit[j]) else begin
            value_errors++;
            $display("FAIL %0t out_head/out_tail/out_data[%0d] expected %h got %h", $time, j,
                     stalled_flit[j], {out_head[j], out_tail[j], out_data[j].payload});
          end
        end
        stalled[j] = out_valid[j] && !out_ready[j];
        stalled_flit[j] = {out_head[j], out_tail[j], out_data[j].payload};
        if (out_valid[j] && out_ready[j]) begin
          check_flit(j);
        end
      end
      assert (!out_valid[port_off] && !in_ready[port_off]) else begin
        other_errors++;
        $display("Disabled port %0d became active at %0t", port_off, $time);
      end
    end
  end

  initial begin
    rst_n = 1'b0;
    in_valid = '0;
    in_head = '0;
    in_tail = '0;
    out_ready = '0;
    for (int i = 0; i < ports; i++) begin
      in_data[i] = '0;
      open_src[i] = -1;
    end
    load_vectors();
    num_vec = vec_port.size();
    if (num_vec == 0) begin
      $display("No vectors were read");
      other_errors++;
    end
    for (int k = 0; k < num_vec; k++) begin
      exp_q[vec_out[k]*ports+vec_port[k]].push_back(k);
    end
    outstanding = num_vec;
    fork
      begin
        repeat (num_vec * cycles_per_vector + reset_cycles) @(posedge clk);
        $display("Timeout with %0d flits outstanding; value errors %0d, other errors %0d",
                 outstanding, value_errors, other_errors);
        $display("Errors found");
        $finish;
      end
    join_none
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (out_valid == '0) else begin
      value_errors++;
      $display("FAIL %0t out_valid expected %h got %h", $time, 5'b0, out_valid);
    end
    assert (in_ready == port_mask) else begin
      value_errors++;
      $display("FAIL %0t in_ready expected %h got %h", $time, port_mask, in_ready);
    end
    fork
      drive_port(router_pkg::port_xp);
      drive_port(router_pkg::port_xm);
      drive_port(router_pkg::port_yp);
      drive_port(router_pkg::port_local);
      begin
        // Flit offered to the disabled port is never taken
        in_valid[port_off] <= 1'b1;
        in_head[port_off] <= 1'b1;
        in_tail[port_off] <= 1'b1;
        in_data[port_off].payload <= 32'h0888_8FFF;
        repeat (20) @(posedge clk);
        in_valid[port_off] <= 1'b0;
      end
    join
    while (outstanding > 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    for (int j = 0; j < ports; j++) begin
      assert (open_src[j] < 0) else begin
        other_errors++;
        $display("Packet on output %0d never reached its tail", j);
      end
    end
    $display("Checked %0d flits; value errors %0d, other errors %0d, assertion failures %0d",
             checked, value_errors, other_errors, dut_i.sva_i.failures);
    if (value_errors + other_errors + dut_i.sva_i.failures == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* tb/router_vectors.txt */
// Flits for the router at (1,1) in a 4x4 mesh, all fields in hex
// in_port head tail data out_port   (port 0 X+, 1 X-, 2 Y+, 3 Y-, 4 local)

// Local input: to (3,1), to itself, to (1,0) on the disabled Y-, to (5,1), to (0,0)
4 1 0 18888001 0
4 0 0 00010101 0
4 0 1 00010102 0
4 1 1 08888002 4
4 1 0 08088003 4
4 0 1 00030301 4
4 1 0 28888004 0
4 0 1 00040401 0
4 1 0 0008800E 1
4 0 0 000E0E01 1
4 0 1 000E0E02 1

// X+ input: to (0,1), to (3,2) with header-like bodies, to (1,7)
0 1 0 00908005 1
0 0 0 00050501 1
0 0 1 00050502 1
0 1 0 19108006 0
0 0 0 FFFF0601 0
0 0 1 FFFF0602 0
0 1 1 0B908007 2

// X- input: to (2,0), to (1,3), to (0,9)
1 1 0 10008008 0
1 0 0 00080801 0
1 0 0 00080802 0
1 0 1 00080803 0
1 1 0 09808009 2
1 0 1 00090901 2
1 1 0 0480800A 1
1 0 1 000A0A01 1

// Y+ input: to (1,1), to (2,2), to (1,2)
2 1 0 0889000B 4
2 0 0 000B0B01 4
2 0 1 000B0B02 4
2 1 0 1109000C 0
2 0 0 7FFF0C01 0
2 0 1 000C0C02 0
2 1 0 0909000D 2
2 0 1 000D0D01 2
